/* common/daq1_cpld_pkg.sv */
// DAQ1 CPLD shared definitions
`default_nettype none

package daq1_cpld_pkg;

  // ****************************************
  // Field widths and frame boundaries
  // ****************************************

  localparam int BYTE_W = 8;
  localparam int ADDR_W = 7;
  localparam int CNT_W  = 6;

  // Bit counts at the end of each byte of a frame
  localparam int SEL_END  = 8;
  localparam int ADDR_END = 16;
  localparam int DATA_END = 24;

  // Read value for addresses outside the map
  localparam logic [BYTE_W-1:0] RD_UNMAPPED = 8'hFA;

  // ****************************************
  // Frame targets
  // ****************************************

  // Any value not listed selects no target
  typedef enum logic [BYTE_W-1:0] {
    DEV_ADC  = 8'h80,
    DEV_DAC  = 8'h81,
    DEV_CLK  = 8'h82,
    DEV_CPLD = 8'h83
  } dev_sel_e;

  // ****************************************
  // Register map
  // ****************************************

  typedef enum logic [ADDR_W-1:0] {
    REG_VERSION  = 7'h00,
    REG_ADC_CTRL = 7'h10,
    REG_DAC_CTRL = 7'h11,
    REG_CLK_CTRL = 7'h12,
    REG_IRQ_MASK = 7'h13,
    REG_ADC_STAT = 7'h20,
    REG_DAC_STAT = 7'h21,
    REG_CLK_STAT = 7'h22
  } reg_addr_e;

  // Frame phases, one per byte plus the tail
  typedef enum logic [1:0] {
    PH_SEL,
    PH_ADDR,
    PH_DATA,
    PH_DONE
  } phase_e;

endpackage

`default_nettype wire

/* source/spi_frame_decode.sv */
// SPI frame decode
`timescale 1ns/1ns
`default_nettype none

module spi_frame_decode (
  input  logic                                     fmc_spi_sclk,
  input  logic                                     fmc_spi_csn,
  input  logic                                     fmc_spi_sdio,
  output daq1_cpld_pkg::dev_sel_e                  dev_sel,
  output daq1_cpld_pkg::reg_addr_e                 reg_addr,
  output logic                                     rdnwr,
  output logic [daq1_cpld_pkg::BYTE_W-1:0]         wdata,
  output logic                                     wr_en,
  output logic [daq1_cpld_pkg::CNT_W-1:0]          bit_count,
  output daq1_cpld_pkg::phase_e                    phase,
  output logic                                     adc_spicsn,
  output logic                                     dac_spicsn,
  output logic                                     clk_spicsn,
  output logic                                     sclk
);

  logic [daq1_cpld_pkg::BYTE_W-1:0] sel_sr;
  logic [daq1_cpld_pkg::BYTE_W-1:0] addr_sr;
  logic [daq1_cpld_pkg::CNT_W-1:0]  count_nxt;
  logic                             cs_on;
  logic                             ext_sel;

  assign count_nxt = bit_count + 1'b1;

  // ****************************************
  // Rising edge, bit count and byte capture
  // ****************************************

  always_ff @(posedge fmc_spi_sclk or posedge fmc_spi_csn) begin
    if (fmc_spi_csn) begin
      bit_count <= '0;
      phase     <= daq1_cpld_pkg::PH_SEL;
      sel_sr    <= '0;
      addr_sr   <= '0;
      wr_en     <= 1'b0;
    end else begin
      // Count saturates so long pass-through frames stay harmless
      if (!(&bit_count)) begin
        bit_count <= count_nxt;
      end
      wr_en <= 1'b0;
      case (phase)
        daq1_cpld_pkg::PH_SEL: begin
          sel_sr <= {sel_sr[daq1_cpld_pkg::BYTE_W-2:0], fmc_spi_sdio};
          if (count_nxt == daq1_cpld_pkg::SEL_END) begin
            phase <= daq1_cpld_pkg::PH_ADDR;
          end
        end
        daq1_cpld_pkg::PH_ADDR: begin
          addr_sr <= {addr_sr[daq1_cpld_pkg::BYTE_W-2:0], fmc_spi_sdio};
          if (count_nxt == daq1_cpld_pkg::ADDR_END) begin
            phase <= daq1_cpld_pkg::PH_DATA;
          end
        end
        daq1_cpld_pkg::PH_DATA: begin
          if (count_nxt == daq1_cpld_pkg::DATA_END) begin
            phase <= daq1_cpld_pkg::PH_DONE;
            // Last data bit arrives on this edge
            wr_en <= (dev_sel == daq1_cpld_pkg::DEV_CPLD) && !rdnwr;
          end
        end
        default: phase <= daq1_cpld_pkg::PH_DONE;
      endcase
    end
  end

  // Data byte shifter
  always_ff @(posedge fmc_spi_sclk) begin
    if (phase == daq1_cpld_pkg::PH_DATA) begin
      wdata <= {wdata[daq1_cpld_pkg::BYTE_W-2:0], fmc_spi_sdio};
    end
  end

  // ****************************************
  // Falling edge, board chip select enable
  // ****************************************

  // Opens once the select byte is complete
  always_ff @(negedge fmc_spi_sclk or posedge fmc_spi_csn) begin
    if (fmc_spi_csn) begin
      cs_on <= 1'b0;
    end else if (phase != daq1_cpld_pkg::PH_SEL) begin
      cs_on <= 1'b1;
    end
  end

  assign dev_sel  = daq1_cpld_pkg::dev_sel_e'(sel_sr);
  assign reg_addr = daq1_cpld_pkg::reg_addr_e'(addr_sr[daq1_cpld_pkg::ADDR_W-1:0]);
  assign rdnwr    = addr_sr[daq1_cpld_pkg::BYTE_W-1];

  assign adc_spicsn = ~(cs_on && (dev_sel == daq1_cpld_pkg::DEV_ADC));
  assign dac_spicsn = ~(cs_on && (dev_sel == daq1_cpld_pkg::DEV_DAC));
  assign clk_spicsn = ~(cs_on && (dev_sel == daq1_cpld_pkg::DEV_CLK));

  // Board clock runs only inside an external chip select window
  assign ext_sel = (dev_sel == daq1_cpld_pkg::DEV_ADC) ||
                   (dev_sel == daq1_cpld_pkg::DEV_DAC) ||
                   (dev_sel == daq1_cpld_pkg::DEV_CLK);
  assign sclk    = fmc_spi_sclk & cs_on & ext_sel;

endmodule

`default_nettype wire

/* cpld_regs/cpld_reg_exec.sv */
// CPLD register file and interrupt
`timescale 1ns/1ns
`default_nettype none

module cpld_reg_exec #(
  parameter logic [7:0] version = 8'h11
) (
  input  logic                              fmc_spi_sclk,
  input  logic                              wr_en,
  input  daq1_cpld_pkg::reg_addr_e          reg_addr,
  input  logic [daq1_cpld_pkg::BYTE_W-1:0]  wdata,
  input  logic                              adc_fda,
  input  logic                              adc_fdb,
  input  logic                              adc_status_p,
  input  logic                              dac_irqn,
  input  logic                              clk_status1,
  input  logic                              clk_status2,
  output logic [daq1_cpld_pkg::BYTE_W-1:0]  rdata,
  output logic                              adc_pwdn_stby,
  output logic                              dac_resetn,
  output logic                              clk_pwdnn,
  output logic                              clk_resetn,
  output logic                              clk_syncn,
  output logic                              fmc_irq
);

  // Control registers persist across frames, power up cleared
  logic [daq1_cpld_pkg::BYTE_W-1:0] adc_ctrl = '0;
  logic [daq1_cpld_pkg::BYTE_W-1:0] dac_ctrl = '0;
  logic [daq1_cpld_pkg::BYTE_W-1:0] clk_ctrl = '0;
  logic [daq1_cpld_pkg::BYTE_W-1:0] irq_mask = '0;
  logic [5:0]                       status_vec;

  // ****************************************
  // Register write
  // ****************************************

  // Falling edge inside the wr_en cycle, before the frame can end
  always_ff @(negedge fmc_spi_sclk) begin
    if (wr_en) begin
      case (reg_addr)
        daq1_cpld_pkg::REG_ADC_CTRL: adc_ctrl <= wdata;
        daq1_cpld_pkg::REG_DAC_CTRL: dac_ctrl <= wdata;
        daq1_cpld_pkg::REG_CLK_CTRL: clk_ctrl <= wdata;
        daq1_cpld_pkg::REG_IRQ_MASK: irq_mask <= wdata;
        // Version and status are read only
        default: ;
      endcase
    end
  end

  // ****************************************
  // Read multiplexer
  // ****************************************

  always_comb begin
    case (reg_addr)
      daq1_cpld_pkg::REG_VERSION:  rdata = version;
      daq1_cpld_pkg::REG_ADC_CTRL: rdata = adc_ctrl;
      daq1_cpld_pkg::REG_DAC_CTRL: rdata = dac_ctrl;
      daq1_cpld_pkg::REG_CLK_CTRL: rdata = clk_ctrl;
      daq1_cpld_pkg::REG_IRQ_MASK: rdata = irq_mask;
      daq1_cpld_pkg::REG_ADC_STAT: rdata = {5'b0, adc_status_p, adc_fdb, adc_fda};
      daq1_cpld_pkg::REG_DAC_STAT: rdata = {7'b0, dac_irqn};
      daq1_cpld_pkg::REG_CLK_STAT: rdata = {6'b0, clk_status2, clk_status1};
      default:                     rdata = daq1_cpld_pkg::RD_UNMAPPED;
    endcase
  end

  // ****************************************
  // Control pins
  // ****************************************

  // ADC power down / standby
  assign adc_pwdn_stby = adc_ctrl[0];

  // DAC reset, active low
  assign dac_resetn = dac_ctrl[0];

  // Clock chip power down, reset and sync
  assign clk_pwdnn  = clk_ctrl[0];
  assign clk_resetn = clk_ctrl[1];
  assign clk_syncn  = clk_ctrl[2];

  // ****************************************
  // Interrupt
  // ****************************************

  assign status_vec = {dac_irqn, clk_status2, clk_status1, adc_status_p, adc_fdb, adc_fda};

  // A set mask bit hides its status bit
  assign fmc_irq = |(status_vec & ~irq_mask[5:0]);

endmodule

`default_nettype wire

/* source/spi_readback.sv */
// SPI bus turnaround and read data
`timescale 1ns/1ns
`default_nettype none

module spi_readback (
  input  logic                              fmc_spi_sclk,
  input  logic                              fmc_spi_csn,
  input  daq1_cpld_pkg::dev_sel_e           dev_sel,
  input  logic                              rdnwr,
  input  logic [daq1_cpld_pkg::CNT_W-1:0]   bit_count,
  input  daq1_cpld_pkg::phase_e             phase,
  input  logic [daq1_cpld_pkg::BYTE_W-1:0]  rdata,
  inout  wire                               fmc_spi_sdio,
  inout  wire                               sdio
);

  logic       to_fpga;
  logic [2:0] rd_index;
  logic       short_instr;
  logic       long_instr;
  logic       turn_now;
  logic       out_bit;

  // DAC and CPLD use an 8-bit instruction, ADC and clock chip 16 bits
  assign short_instr = (dev_sel == daq1_cpld_pkg::DEV_CPLD) ||
                       (dev_sel == daq1_cpld_pkg::DEV_DAC);
  assign long_instr  = (dev_sel == daq1_cpld_pkg::DEV_ADC) ||
                       (dev_sel == daq1_cpld_pkg::DEV_CLK);

  assign turn_now = rdnwr &&
                    ((short_instr && (bit_count == daq1_cpld_pkg::ADDR_END)) ||
                     (long_instr && (bit_count == daq1_cpld_pkg::DATA_END)));

  // ****************************************
  // Direction and read bit index
  // ****************************************

  always_ff @(negedge fmc_spi_sclk or posedge fmc_spi_csn) begin
    if (fmc_spi_csn) begin
      to_fpga  <= 1'b0;
      rd_index <= 3'd7;
    end else begin
      if (turn_now) begin
        to_fpga <= 1'b1;
      end
      // MSB goes out at the turnaround edge, one bit lower per edge after
      if (to_fpga && (phase != daq1_cpld_pkg::PH_DONE)) begin
        rd_index <= rd_index - 1'b1;
      end
    end
  end

  // ****************************************
  // Tristate buffers
  // ****************************************

  assign out_bit = (dev_sel == daq1_cpld_pkg::DEV_CPLD) ? rdata[rd_index] : sdio;

  assign fmc_spi_sdio = to_fpga ? out_bit : 1'bz;
  assign sdio         = to_fpga ? 1'bz : fmc_spi_sdio;

endmodule

`default_nettype wire

/* source/daq1_cpld.sv */
// DAQ1 configuration CPLD top level
`timescale 1ns/1ns
`default_nettype none

module daq1_cpld #(
  parameter logic [7:0] version = 8'h11
) (
  // FMC side SPI and interrupt
  input  logic fmc_spi_sclk,
  input  logic fmc_spi_csn,
  inout  wire  fmc_spi_sdio,
  output logic fmc_irq,

  // Board side SPI
  output logic adc_spicsn,
  output logic dac_spicsn,
  output logic clk_spicsn,
  output logic sclk,
  inout  wire  sdio,

  // ADC control and status
  input  logic adc_fda,
  input  logic adc_fdb,
  input  logic adc_status_p,
  // Complement of the status pair, status is taken from the p side
  input  logic adc_status_n,
  output logic adc_pwdn_stby,

  // DAC control and status
  input  logic dac_irqn,
  output logic dac_resetn,

  // Clock chip control and status
  input  logic clk_status1,
  input  logic clk_status2,
  output logic clk_pwdnn,
  output logic clk_syncn,
  output logic clk_resetn
);

  daq1_cpld_pkg::dev_sel_e          dev_sel;
  daq1_cpld_pkg::reg_addr_e         reg_addr;
  daq1_cpld_pkg::phase_e            phase;
  logic                             rdnwr;
  logic                             wr_en;
  logic [daq1_cpld_pkg::BYTE_W-1:0] wdata;
  logic [daq1_cpld_pkg::BYTE_W-1:0] rdata;
  logic [daq1_cpld_pkg::CNT_W-1:0]  bit_count;

  // ****************************************
  // Decode, execute and result stages
  // ****************************************

  spi_frame_decode decode_i (
    .fmc_spi_sclk (fmc_spi_sclk),
    .fmc_spi_csn  (fmc_spi_csn),
    .fmc_spi_sdio (fmc_spi_sdio),
    .dev_sel      (dev_sel),
    .reg_addr     (reg_addr),
    .rdnwr        (rdnwr),
    .wdata        (wdata),
    .wr_en        (wr_en),
    .bit_count    (bit_count),
    .phase        (phase),
    .adc_spicsn   (adc_spicsn),
    .dac_spicsn   (dac_spicsn),
    .clk_spicsn   (clk_spicsn),
    .sclk         (sclk)
  );

  cpld_reg_exec #(
    .version (version)
  ) exec_i (
    .fmc_spi_sclk  (fmc_spi_sclk),
    .wr_en         (wr_en),
    .reg_addr      (reg_addr),
    .wdata         (wdata),
    .adc_fda       (adc_fda),
    .adc_fdb       (adc_fdb),
    .adc_status_p  (adc_status_p),
    .dac_irqn      (dac_irqn),
    .clk_status1   (clk_status1),
    .clk_status2   (clk_status2),
    .rdata         (rdata),
    .adc_pwdn_stby (adc_pwdn_stby),
    .dac_resetn    (dac_resetn),
    .clk_pwdnn     (clk_pwdnn),
    .clk_resetn    (clk_resetn),
    .clk_syncn     (clk_syncn),
    .fmc_irq       (fmc_irq)
  );

  spi_readback result_i (
    .fmc_spi_sclk (fmc_spi_sclk),
    .fmc_spi_csn  (fmc_spi_csn),
    .dev_sel      (dev_sel),
    .rdnwr        (rdnwr),
    .bit_count    (bit_count),
    .phase        (phase),
    .rdata        (rdata),
    .fmc_spi_sdio (fmc_spi_sdio),
    .sdio         (sdio)
  );

endmodule

`default_nettype wire

/* bench/daq1_cpld_sva.sv */
// SPI bus assertions
`timescale 1ns/1ns
`default_nettype none

module daq1_cpld_sva #(
  parameter bit check_cs = 1'b1
) (
  input logic       fmc_spi_sclk,
  input logic       fmc_spi_csn,
  input logic [2:0] cs_n,
  input logic       sdio_oe
);

  if (check_cs) begin : g_cs
    // At most one board chip select low
    cs_exclusive_a: assert property (@(posedge fmc_spi_sclk) $onehot0(~cs_n))
      else $error("more than one board chip select is low");
  end else begin : g_dir
    // Idle bus seen at the start of every frame
    idle_dir_a: assert property (@(negedge fmc_spi_csn) !sdio_oe)
      else $error("FMC data line driven between frames");
  end

endmodule

// Decode owns the chip selects, readback owns the direction
bind spi_frame_decode daq1_cpld_sva #(
  .check_cs (1'b1)
) decode_sva_i (
  .fmc_spi_sclk (fmc_spi_sclk),
  .fmc_spi_csn  (fmc_spi_csn),
  .cs_n         ({adc_spicsn, dac_spicsn, clk_spicsn}),
  .sdio_oe      (1'b0)
);

bind spi_readback daq1_cpld_sva #(
  .check_cs (1'b0)
) result_sva_i (
  .fmc_spi_sclk (fmc_spi_sclk),
  .fmc_spi_csn  (fmc_spi_csn),
  .cs_n         (3'b111),
  .sdio_oe      (to_fpga)
);

`default_nettype wire

/* bench/tb_daq1_cpld.sv */
// DAQ1 CPLD trace testbench
`timescale 1ns/1ns
`default_nettype none

module tb_daq1_cpld;

  localparam int TRACE_COLS   = 7;
  localparam int TRACE_LINES  = 40;
  localparam int IDLE_TIMEOUT = 16;

  logic clk;
  logic sclk_en;
  logic fmc_spi_csn;
  logic host_oe;
  logic host_bit;
  logic adc_fda;
  logic adc_fdb;
  logic adc_status_p;
  logic adc_status_n;
  logic dac_irqn;
  logic clk_status1;
  logic clk_status2;

  wire  fmc_spi_sclk;
  wire  fmc_spi_sdio;
  wire  sdio;
  logic fmc_irq;
  logic adc_spicsn;
  logic dac_spicsn;
  logic clk_spicsn;
  logic sclk;
  logic adc_pwdn_stby;
  logic dac_resetn;
  logic clk_pwdnn;
  logic clk_syncn;
  logic clk_resetn;

  // Board chip model state
  logic       pin_read_en;
  logic [7:0] pin_byte;
  int         pin_instr_len;
  logic       pin_oe = 1'b0;
  logic [7:0] pin_sr = '0;
  int         board_edges = 0;

  logic [7:0] trace_mem [0:TRACE_COLS*TRACE_LINES-1];

  assign fmc_spi_sclk = clk & sclk_en;
  assign fmc_spi_sdio = host_oe ? host_bit : 1'bz;
  assign sdio         = pin_oe ? pin_sr[7] : 1'bz;

  daq1_cpld #(
    .version (8'h11)
  ) dut_i (
    .fmc_spi_sclk  (fmc_spi_sclk),
    .fmc_spi_csn   (fmc_spi_csn),
    .fmc_spi_sdio  (fmc_spi_sdio),
    .fmc_irq       (fmc_irq),
    .adc_spicsn    (adc_spicsn),
    .dac_spicsn    (dac_spicsn),
    .clk_spicsn    (clk_spicsn),
    .sclk          (sclk),
    .sdio          (sdio),
    .adc_fda       (adc_fda),
    .adc_fdb       (adc_fdb),
    .adc_status_p  (adc_status_p),
    .adc_status_n  (adc_status_n),
    .adc_pwdn_stby (adc_pwdn_stby),
    .dac_irqn      (dac_irqn),
    .dac_resetn    (dac_resetn),
    .clk_status1   (clk_status1),
    .clk_status2   (clk_status2),
    .clk_pwdnn     (clk_pwdnn),
    .clk_syncn     (clk_syncn),
    .clk_resetn    (clk_resetn)
  );

  // ****************************************
  // Board chip data line model
  // ****************************************

  // Counts board clock edges of the instruction
  always @(posedge sclk or posedge fmc_spi_csn) begin
    if (fmc_spi_csn) begin
      board_edges <= 0;
    end else begin
      board_edges <= board_edges + 1;
    end
  end

  // Read byte goes out MSB first once the instruction is in
  always @(negedge clk or posedge fmc_spi_csn) begin
    if (fmc_spi_csn) begin
      pin_oe <= 1'b0;
    end else if (pin_oe) begin
      pin_sr <= {pin_sr[6:0], 1'b0};
    end else if (pin_read_en && (board_edges == pin_instr_len)) begin
      pin_oe <= 1'b1;
      pin_sr <= pin_byte;
    end
  end

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ****************************************
  // Checks and helpers
  // ****************************************

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected);
      abort_run();
    end
  endtask

  function automatic logic [7:0] control_pins();
    return {3'b000, clk_syncn, clk_resetn, clk_pwdnn, dac_resetn, adc_pwdn_stby};
  endfunction

  // Chip select pattern {adc, dac, clk} for a board target
  function automatic logic [2:0] target_cs(input logic [7:0] dev);
    case (dev)
      8'h80:   return 3'b011;
      8'h81:   return 3'b101;
      8'h82:   return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  task automatic apply_status(input logic [5:0] st);
    adc_fda      = st[0];
    adc_fdb      = st[1];
    adc_status_p = st[2];
    adc_status_n = ~st[2];
    clk_status1  = st[3];
    clk_status2  = st[4];
    dac_irqn     = st[5];
  endtask

  task automatic wait_idle();
    int   cycles;
    logic idle;
    cycles = 0;
    idle   = 1'b0;
    while (!idle) begin
      #2;
      idle = adc_spicsn && dac_spicsn && clk_spicsn && !sclk;
      if (!idle) begin
        if (cycles == IDLE_TIMEOUT) begin
          $display("Board chip selects did not return high after the frame");
          abort_run();
        end else begin
          @(negedge clk);
          cycles++;
        end
      end
    end
  endtask

  // One frame, called on a falling edge; turn is 0 when the host drives throughout
  task automatic run_frame(input logic [7:0] dev, input logic [31:0] tx, input int nbits,
                           input int turn, output logic [7:0] rx,
                           output logic [7:0] board_rx);
    logic       ext;
    logic [2:0] cs_exp;
    ext      = (dev == 8'h80) || (dev == 8'h81) || (dev == 8'h82);
    rx       = '0;
    board_rx = '0;
    fmc_spi_csn = 1'b0;
    host_oe     = 1'b1;
    host_bit    = tx[31];
    sclk_en     = 1'b1;
    for (int k = 1; k <= nbits; k++) begin
      @(posedge clk);
      #2;
      cs_exp = (ext && (k > 8)) ? target_cs(dev) : 3'b111;
      check_value("chip selects", {adc_spicsn, dac_spicsn, clk_spicsn}, cs_exp);
      check_value("sclk", sclk, ext && (k > 8));
      if ((turn == 0) || (k <= turn)) begin
        check_value("sdio", sdio, host_bit);
      end
      rx       = {rx[6:0], fmc_spi_sdio};
      board_rx = {board_rx[6:0], sdio};
      @(negedge clk);
      if (k == turn) begin
        host_oe = 1'b0;
      end
      if (k == nbits) begin
        sclk_en = 1'b0;
      end else begin
        host_bit = tx[31-k];
      end
      #2;
      check_value("sclk", sclk, 1'b0);
    end
    @(negedge clk);
    fmc_spi_csn = 1'b1;
    host_oe     = 1'b1;
    host_bit    = 1'b0;
    wait_idle();
  endtask

  task automatic replay_line(input logic [7:0] ftype, input logic [7:0] dev,
                             input logic [7:0] addr, input logic [7:0] data,
                             input logic [7:0] status, input logic [7:0] expected,
                             input logic [7:0] irq);
    logic [31:0] tx;
    logic [7:0]  rx;
    logic [7:0]  board_rx;
    logic        long_instr;
    int          nbits;
    int          turn;
    long_instr    = (dev == 8'h80) || (dev == 8'h82);
    tx            = {dev, addr, data, 8'h00};
    nbits         = 24;
    turn          = 0;
    pin_read_en   = 1'b0;
    pin_byte      = data;
    pin_instr_len = long_instr ? 16 : 8;
    case (ftype)
      8'h00, 8'h02: ;
      8'h01: turn = 16;
      8'h03: begin
        // ADC and clock chip take a second instruction byte
        tx          = {dev, addr, 16'h0000};
        turn        = long_instr ? 24 : 16;
        nbits       = turn + 8;
        pin_read_en = 1'b1;
      end
      default: begin
        $display("Trace holds an unknown frame type 0x%0h", ftype);
        abort_run();
      end
    endcase
    @(negedge clk);
    apply_status(status[5:0]);
    run_frame(dev, tx, nbits, turn, rx, board_rx);
    case (ftype)
      8'h00:   check_value("control pins", control_pins(), expected);
      8'h02:   check_value("sdio byte", board_rx, expected);
      default: check_value("fmc_spi_sdio byte", rx, expected);
    endcase
    check_value("fmc_irq", fmc_irq, irq[0]);
  endtask

  // ****************************************
  // Main sequence
  // ****************************************

  initial begin
    int   line;
    int   base;
    logic done;
    sclk_en     = 1'b0;
    fmc_spi_csn = 1'b1;
    host_oe     = 1'b1;
    host_bit    = 1'b0;
    pin_read_en = 1'b0;
    pin_byte    = '0;
    pin_instr_len = 8;
    apply_status(6'h00);
    $readmemh("bench/daq1_trace.txt", trace_mem);
    repeat (10) @(negedge clk);
    #2;
    check_value("chip selects", {adc_spicsn, dac_spicsn, clk_spicsn}, 3'b111);
    check_value("sclk", sclk, 1'b0);
    line = 0;
    done = 1'b0;
    while (!done) begin
      if (line == TRACE_LINES) begin
        $display("Trace has no end marker");
        abort_run();
      end else begin
        base = line * TRACE_COLS;
        if (trace_mem[base] == 8'hFF) begin
          done = 1'b1;
        end else begin
          replay_line(trace_mem[base], trace_mem[base+1], trace_mem[base+2],
                      trace_mem[base+3], trace_mem[base+4], trace_mem[base+5],
                      trace_mem[base+6]);
          line++;
        end
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/daq1_trace.txt */
// type dev addr data status expect irq; type 00 CPLD write, 01 CPLD read, 02 board write,
// 03 board read, FF end; status bits 0..5 fda fdb status_p clk_st1 clk_st2 dac_irqn
01 83 80 00 00 11 0
01 83 85 00 00 FA 0
00 83 10 01 00 01 0
00 83 11 01 00 03 0
00 83 12 07 00 1F 0
01 83 90 00 00 01 0
01 83 91 00 00 01 0
01 83 92 00 00 07 0
00 83 12 05 00 17 0
00 83 20 FF 00 17 0
00 83 00 55 00 17 0
01 83 80 00 00 11 0
01 83 A0 00 07 07 1
01 83 A1 00 20 01 1
01 83 A2 00 18 03 1
00 83 13 18 18 17 0
01 83 93 00 19 18 1
00 83 13 3F 3F 17 0
00 83 13 00 00 17 0
01 83 A0 00 02 02 1
02 80 05 A5 00 A5 0
02 81 0C 3C 00 3C 0
02 82 12 C3 00 C3 0
03 81 8A 96 00 96 0
03 80 81 5A 00 5A 0
03 82 93 E7 00 E7 0
01 83 91 00 00 01 0
FF 00 00 00 00 00 0

/* tb.f */
common/daq1_cpld_pkg.sv
source/spi_frame_decode.sv
cpld_regs/cpld_reg_exec.sv
source/spi_readback.sv
source/daq1_cpld.sv
bench/daq1_cpld_sva.sv
bench/tb_daq1_cpld.sv

/* Makefile */
TOP := tb_daq1_cpld

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f tb.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Test OK$$" sim.log

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log
